// File: rename_core.f
logic/rename_pkg.sv
logic/free_list.sv
logic/rename_table.sv
logic/rename_dispatch.sv
logic/station.sv
logic/issue_select.sv
logic/rename_core.sv
test/rename_core_checker.sv
test/rename_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rename core simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rename_core.f \
    --top-module rename_core_tb -o rename_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/rename_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -F '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: test/rename_core_tb.sv
module rename_core_tb;
    import rename_pkg::*;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        inst_valid;
    logic        inst_taken;
    logic        wb_valid;
    logic [phys_bits-1:0] wb_pd;
    logic        commit_valid;
    logic [phys_bits-1:0] commit_pd;
    logic        issue_valid;
    logic [class_bits-1:0] issue_class;
    logic [31:0] issue_inst;
    logic [31:0] issue_pc;
    logic [phys_bits-1:0] issue_pd;
    logic [phys_bits-1:0] issue_ps1;
    logic [phys_bits-1:0] issue_ps2;

    // reference model state
    logic [phys_bits-1:0] map_m [32];
    logic                 ready_m [phys_count];
    logic [phys_bits-1:0] free_q [$];
    logic [phys_bits-1:0] stale_q [$];

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          err_mark;

    // stimulus table
    localparam int rows = 9;
    logic [31:0]           t_inst [rows];
    logic                  t_taken [rows];
    logic [class_bits-1:0] t_class [rows];
    logic [phys_bits-1:0]  t_pd [rows];

    rename_core dut0 (.*);

    bind rename_core rename_core_checker chk0 (
        .clk(clk), .rst(rst), .fl_pop(fl_pop), .fl_head(fl_head),
        .issue_valid(issue_valid), .issue_pd(issue_pd),
        .issue_ps1(issue_ps1), .issue_ps2(issue_ps2)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] enc(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // galois lfsr, one step per bit
    function automatic logic [4:0] rand5();
        logic [4:0] v;
        v = '0;
        for (int i = 0; i < 5; i++) begin
            v    = {v[3:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [4:0] src1(logic [31:0] w);
        return (w[6:0] inside {op_lui, op_auipc, op_jal}) ? 5'd0 : w[19:15];
    endfunction

    function automatic logic [4:0] src2(logic [31:0] w);
        return (w[6:0] inside {op_br, op_store, op_reg}) ? w[24:20] : 5'd0;
    endfunction

    task automatic check_val(string name, int got, int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(bit cond, string msg);
        checks++;
        assert (cond) else begin
            $display("ERROR t=%0t %s", $time, msg);
            errors++;
        end
    endtask

    task automatic rename_model(logic [31:0] w, output logic [phys_bits-1:0] pd);
        logic [4:0] rd;
        rd = w[11:7];
        pd = '0;
        if (rd != 0 && w[6:0] != op_br && w[6:0] != op_store) begin
            pd = free_q.pop_front();
            stale_q.push_back(map_m[rd]);
            map_m[rd]  = pd;
            ready_m[pd] = 1'b0;
        end
    endtask

    // hold the word at the queue head until taken or out of cycles
    task automatic present(logic [31:0] w, int limit, output bit taken,
                           output logic [phys_bits-1:0] pd, output logic [phys_bits-1:0] ps1,
                           output logic [phys_bits-1:0] ps2);
        int n;
        n     = 0;
        taken = 0;
        pd    = '0;
        inst       = w;
        pc         = pc + 4;
        inst_valid = 1'b1;
        while (!taken && n < limit) begin
            #1;
            if (inst_taken) begin
                taken = 1;
                ps1   = map_m[src1(w)];
                ps2   = map_m[src2(w)];
                rename_model(w, pd);
            end
            @(negedge clk);
            n++;
        end
        inst_valid = 1'b0;
    endtask

    task automatic wait_issue(int limit, output bit got);
        int n;
        n   = 0;
        got = 0;
        while (!got && n < limit) begin
            @(negedge clk);
            n++;
            got = issue_valid;
        end
    endtask

    task automatic check_issue(logic [class_bits-1:0] cls, logic [phys_bits-1:0] pd,
                               logic [phys_bits-1:0] ps1, logic [phys_bits-1:0] ps2,
                               logic [31:0] w, logic [31:0] wpc);
        check_val("issue_class", issue_class, cls);
        check_val("issue_pd", issue_pd, pd);
        check_val("issue_ps1", issue_ps1, ps1);
        check_val("issue_ps2", issue_ps2, ps2);
        check_val("issue_inst", issue_inst, w);
        check_val("issue_pc", issue_pc, wpc);
    endtask

    task automatic pulse_wb(logic [phys_bits-1:0] pd);
        wb_valid = 1'b1;
        wb_pd    = pd;
        @(negedge clk);
        wb_valid    = 1'b0;
        ready_m[pd] = 1'b1;
    endtask

    task automatic pulse_commit(logic [phys_bits-1:0] pd);
        commit_valid = 1'b1;
        commit_pd    = pd;
        @(negedge clk);
        commit_valid = 1'b0;
        free_q.push_back(pd);
    endtask

    task automatic end_test(string name);
        $display("test %-16s %s (%0d errors)", name,
                 (errors == err_mark) ? "ok" : "bad", errors - err_mark);
        err_mark = errors;
    endtask

    // take one instruction whose sources are ready and see it issue
    task automatic run_one(logic [31:0] w, logic [class_bits-1:0] cls,
                           output logic [phys_bits-1:0] pd);
        bit taken;
        bit got;
        logic [phys_bits-1:0] ps1;
        logic [phys_bits-1:0] ps2;
        present(w, 8, taken, pd, ps1, ps2);
        check_true(taken, "instruction was not taken");
        wait_issue(10, got);
        check_true(got, "timeout waiting for issue_valid");
        check_issue(cls, pd, ps1, ps2, w, pc);
    endtask

    initial begin
        logic [phys_bits-1:0] pd;
        logic [phys_bits-1:0] ps1;
        logic [phys_bits-1:0] ps2;
        logic [phys_bits-1:0] p;
        logic [phys_bits-1:0] c;
        logic [phys_bits-1:0] mpd [4];
        logic [31:0] minst [4];
        logic [31:0] mpc [4];
        logic [31:0] w;
        bit taken;
        bit got;
        clk          = 0;
        rst          = 1;
        inst         = '0;
        pc           = '0;
        inst_valid   = 0;
        wb_valid     = 0;
        wb_pd        = '0;
        commit_valid = 0;
        commit_pd    = '0;
        lfsr         = 32'h80d1;
        errors       = 0;
        checks       = 0;
        err_mark     = 0;
        for (int i = 0; i < 32; i++) map_m[i] = phys_bits'(i);
        for (int i = 0; i < phys_count; i++) ready_m[i] = 1'b1;
        for (int i = 32; i < 64; i++) free_q.push_back(phys_bits'(i));

        t_inst[0] = enc(7'd0, 5'd3, 5'd2, 3'd0, 5'd1, op_reg);     // add x1,x2,x3
        t_inst[1] = enc(7'd1, 5'd5, 5'd1, 3'd0, 5'd4, op_reg);     // mul x4,x1,x5
        t_inst[2] = enc(7'd1, 5'd1, 5'd4, 3'd5, 5'd6, op_reg);     // divu x6,x4,x1
        t_inst[3] = enc(7'd0, 5'd4, 5'd1, 3'd0, 5'd0, op_br);      // beq x1,x4
        t_inst[4] = enc(7'd0, 5'd0, 5'd6, 3'd2, 5'd7, op_load);    // lw x7,0(x6)
        t_inst[5] = enc(7'd0, 5'd7, 5'd1, 3'd2, 5'd4, op_store);   // sw x7,4(x1)
        t_inst[6] = 32'h13;
        t_inst[7] = enc(7'd0, 5'd2, 5'd1, 3'd0, 5'd0, op_reg);     // add x0,x1,x2
        t_inst[8] = 32'h0;
        t_class = '{class_alu, class_mul, class_div, class_br, class_mem,
                    class_mem, class_alu, class_alu, class_alu};
        t_pd    = '{6'd32, 6'd33, 6'd34, 6'd0, 6'd35, 6'd0, 6'd0, 6'd0, 6'd0};
        t_taken = '{1, 1, 1, 1, 1, 1, 1, 1, 1};

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 0;

        // classification and rename
        for (int r = 0; r < rows; r++) begin
            present(t_inst[r], 8, taken, pd, ps1, ps2);
            check_val("inst_taken", taken, t_taken[r]);
            wait_issue(10, got);
            check_true(got, "timeout waiting for issue_valid");
            check_issue(t_class[r], t_pd[r], ps1, ps2, t_inst[r], pc);
            if (pd != 0) pulse_wb(pd);
        end
        end_test("classify_rename");

        // wake-up on writeback
        run_one(enc(7'd0, 5'd2, 5'd1, 3'd0, 5'd8, op_reg), class_alu, p);
        w = enc(7'd32, 5'd8, 5'd8, 3'd0, 5'd9, op_reg);            // sub x9,x8,x8
        present(w, 8, taken, pd, ps1, ps2);
        check_true(taken, "dependent instruction was not taken");
        wait_issue(10, got);
        check_true(!got, "instruction issued before its source was written back");
        pulse_wb(p);
        wait_issue(10, got);
        check_true(got, "timeout waiting for issue after writeback");
        check_issue(class_alu, pd, p, p, w, pc);
        pulse_wb(pd);
        end_test("wakeup");

        // drain the free list with random writers
        while (stale_q.size() > 0) pulse_commit(stale_q.pop_front());
        for (int i = 0; i < 32; i++) begin
            w = enc(7'd0, rand5(), rand5(), 3'd0, 5'd0, op_reg);
            w[11:7] = rand5();
            if (w[11:7] == 0) w[11:7] = 5'd1;
            run_one(w, class_alu, pd);
            pulse_wb(pd);
        end
        present(w, 5, taken, pd, ps1, ps2);
        check_true(!taken, "instruction taken with an empty free list");
        c = stale_q.pop_front();
        pulse_commit(c);
        run_one(w, class_alu, pd);
        check_val("issue_pd", issue_pd, c);
        pulse_wb(pd);
        end_test("free_list_full");

        // fill the mul station behind an unready register
        repeat (8) pulse_commit(stale_q.pop_front());
        run_one(enc(7'd0, 5'd2, 5'd1, 3'd0, 5'd10, op_reg), class_alu, p);
        for (int i = 0; i < 4; i++) begin
            minst[i] = enc(7'd1, 5'd0, 5'd10, 3'd0, 5'(11 + i), op_reg);
            present(minst[i], 8, taken, mpd[i], ps1, ps2);
            mpc[i] = pc;
            check_true(taken, "mul behind an unready register was not taken");
        end
        present(enc(7'd1, 5'd0, 5'd10, 3'd0, 5'd15, op_reg), 5, taken, pd, ps1, ps2);
        check_true(!taken, "mul taken into a full station");
        run_one(enc(7'd0, 5'd2, 5'd1, 3'd0, 5'd16, op_reg), class_alu, pd);
        pulse_wb(pd);
        pulse_wb(p);
        for (int i = 0; i < 4; i++) begin
            wait_issue(10, got);
            check_true(got, "timeout waiting for mul issue");
            check_issue(class_mul, mpd[i], p, 6'd0, minst[i], mpc[i]);
        end
        end_test("station_full");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/rename_core_checker.sv
module rename_core_checker (
    input logic                             clk,
    input logic                             rst,
    input logic                             fl_pop,
    input logic [rename_pkg::phys_bits-1:0]  fl_head,
    input logic                             issue_valid,
    input logic [rename_pkg::phys_bits-1:0]  issue_pd,
    input logic [rename_pkg::phys_bits-1:0]  issue_ps1,
    input logic [rename_pkg::phys_bits-1:0]  issue_ps2
);
    import rename_pkg::*;

    // one issue per instruction, never repeated
    assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue_pd != '0) |=> !(issue_valid && issue_pd == $past(issue_pd)))
        else $error("issue_pd %0d issued twice in a row", $past(issue_pd));

    // physical 0 backs x0 and is never handed out
    assert property (@(posedge clk) disable iff (rst) fl_pop |-> (fl_head != '0))
        else $error("free list handed out physical register 0");

    // a fresh destination never aliases a live source
    assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue_pd != '0) |-> (issue_pd != issue_ps1 && issue_pd != issue_ps2))
        else $error("issue_pd %0d matches one of its source registers", issue_pd);

endmodule

// File: logic/rename_core.sv
module rename_core (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [31:0]                      inst,
    input  logic [31:0]                      pc,
    input  logic                             inst_valid,
    output logic                             inst_taken,
    input  logic                             wb_valid,
    input  logic [rename_pkg::phys_bits-1:0]  wb_pd,
    input  logic                             commit_valid,
    input  logic [rename_pkg::phys_bits-1:0]  commit_pd,
    output logic                             issue_valid,
    output logic [rename_pkg::class_bits-1:0] issue_class,
    output logic [31:0]                      issue_inst,
    output logic [31:0]                      issue_pc,
    output logic [rename_pkg::phys_bits-1:0]  issue_pd,
    output logic [rename_pkg::phys_bits-1:0]  issue_ps1,
    output logic [rename_pkg::phys_bits-1:0]  issue_ps2
);
    import rename_pkg::*;

    logic                  fl_empty;
    logic                  fl_pop;
    logic [phys_bits-1:0]  fl_head;
    logic [arch_bits-1:0]  rs1;
    logic [arch_bits-1:0]  rs2;
    logic [phys_bits-1:0]  ps1;
    logic [phys_bits-1:0]  ps2;
    logic                  rdy1;
    logic                  rdy2;
    logic                  map_we;
    logic [arch_bits-1:0]  map_rd;
    logic [phys_bits-1:0]  map_pd;

    // shared station write bus
    logic [class_count-1:0] st_full;
    logic [class_count-1:0] st_write;
    logic [31:0]            st_inst;
    logic [31:0]            st_pc;
    logic [phys_bits-1:0]   st_pd;
    logic [phys_bits-1:0]   st_ps1;
    logic [phys_bits-1:0]   st_ps2;
    logic                   st_rdy1;
    logic                   st_rdy2;

    // per-station request fields
    logic [class_count-1:0]                st_req;
    logic [class_count-1:0]                grant;
    logic [class_count-1:0][31:0]          r_inst;
    logic [class_count-1:0][31:0]          r_pc;
    logic [class_count-1:0][phys_bits-1:0] r_pd;
    logic [class_count-1:0][phys_bits-1:0] r_ps1;
    logic [class_count-1:0][phys_bits-1:0] r_ps2;

    free_list u_free_list (
        .clk     (clk),
        .rst     (rst),
        .pop     (fl_pop),
        .push    (commit_valid),
        .push_pd (commit_pd),
        .head_pd (fl_head),
        .empty   (fl_empty)
    );

    rename_table u_rename_table (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .ps1      (ps1),
        .ps2      (ps2),
        .rdy1     (rdy1),
        .rdy2     (rdy2),
        .map_we   (map_we),
        .map_rd   (map_rd),
        .map_pd   (map_pd),
        .wb_valid (wb_valid),
        .wb_pd    (wb_pd)
    );

    rename_dispatch u_rename_dispatch (
        .inst       (inst),
        .pc         (pc),
        .inst_valid (inst_valid),
        .inst_taken (inst_taken),
        .fl_empty   (fl_empty),
        .fl_head    (fl_head),
        .fl_pop     (fl_pop),
        .rs1        (rs1),
        .rs2        (rs2),
        .ps1        (ps1),
        .ps2        (ps2),
        .rdy1       (rdy1),
        .rdy2       (rdy2),
        .map_we     (map_we),
        .map_rd     (map_rd),
        .map_pd     (map_pd),
        .st_full    (st_full),
        .st_write   (st_write),
        .st_inst    (st_inst),
        .st_pc      (st_pc),
        .st_pd      (st_pd),
        .st_ps1     (st_ps1),
        .st_ps2     (st_ps2),
        .st_rdy1    (st_rdy1),
        .st_rdy2    (st_rdy2)
    );

    // one station per class
    for (genvar k = 0; k < class_count; k++) begin : g_station
        station u_station (
            .clk      (clk),
            .rst      (rst),
            .write    (st_write[k]),
            .w_inst   (st_inst),
            .w_pc     (st_pc),
            .w_pd     (st_pd),
            .w_ps1    (st_ps1),
            .w_ps2    (st_ps2),
            .w_rdy1   (st_rdy1),
            .w_rdy2   (st_rdy2),
            .wb_valid (wb_valid),
            .wb_pd    (wb_pd),
            .full     (st_full[k]),
            .req      (st_req[k]),
            .r_inst   (r_inst[k]),
            .r_pc     (r_pc[k]),
            .r_pd     (r_pd[k]),
            .r_ps1    (r_ps1[k]),
            .r_ps2    (r_ps2[k]),
            .grant    (grant[k])
        );
    end

    issue_select u_issue_select (
        .clk         (clk),
        .rst         (rst),
        .req         (st_req),
        .r_inst      (r_inst),
        .r_pc        (r_pc),
        .r_pd        (r_pd),
        .r_ps1       (r_ps1),
        .r_ps2       (r_ps2),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue_class (issue_class),
        .issue_inst  (issue_inst),
        .issue_pc    (issue_pc),
        .issue_pd    (issue_pd),
        .issue_ps1   (issue_ps1),
        .issue_ps2   (issue_ps2)
    );

endmodule

// File: logic/issue_select.sv
module issue_select (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [rename_pkg::class_count-1:0]                   req,
    input  logic [rename_pkg::class_count-1:0][31:0]             r_inst,
    input  logic [rename_pkg::class_count-1:0][31:0]             r_pc,
    input  logic [rename_pkg::class_count-1:0][rename_pkg::phys_bits-1:0] r_pd,
    input  logic [rename_pkg::class_count-1:0][rename_pkg::phys_bits-1:0] r_ps1,
    input  logic [rename_pkg::class_count-1:0][rename_pkg::phys_bits-1:0] r_ps2,
    output logic [rename_pkg::class_count-1:0]                   grant,
    output logic                                                 issue_valid,
    output logic [rename_pkg::class_bits-1:0]                    issue_class,
    output logic [31:0]                                          issue_inst,
    output logic [31:0]                                          issue_pc,
    output logic [rename_pkg::phys_bits-1:0]                     issue_pd,
    output logic [rename_pkg::phys_bits-1:0]                     issue_ps1,
    output logic [rename_pkg::phys_bits-1:0]                     issue_ps2
);
    import rename_pkg::*;

    logic [class_bits-1:0] pick;

    // lowest class index wins
    always_comb begin
        pick = '0;
        for (int i = class_count - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick = class_bits'(i);
            end
        end
        grant = '0;
        if (|req) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |req;
        end
    end

    always_ff @(posedge clk) begin
        issue_class <= pick;
        issue_inst  <= r_inst[pick];
        issue_pc    <= r_pc[pick];
        issue_pd    <= r_pd[pick];
        issue_ps1   <= r_ps1[pick];
        issue_ps2   <= r_ps2[pick];
    end

endmodule

// File: logic/station.sv
module station (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            write,
    input  logic [31:0]                     w_inst,
    input  logic [31:0]                     w_pc,
    input  logic [rename_pkg::phys_bits-1:0] w_pd,
    input  logic [rename_pkg::phys_bits-1:0] w_ps1,
    input  logic [rename_pkg::phys_bits-1:0] w_ps2,
    input  logic                            w_rdy1,
    input  logic                            w_rdy2,
    input  logic                            wb_valid,
    input  logic [rename_pkg::phys_bits-1:0] wb_pd,
    output logic                            full,
    output logic                            req,
    output logic [31:0]                     r_inst,
    output logic [31:0]                     r_pc,
    output logic [rename_pkg::phys_bits-1:0] r_pd,
    output logic [rename_pkg::phys_bits-1:0] r_ps1,
    output logic [rename_pkg::phys_bits-1:0] r_ps2,
    input  logic                            grant
);
    import rename_pkg::*;

    logic [station_depth-1:0]    valid;
    // age counts the younger entries still present
    logic [station_idx_bits-1:0] age [station_depth];
    logic [31:0]                 e_inst [station_depth];
    logic [31:0]                 e_pc [station_depth];
    logic [phys_bits-1:0]        e_pd [station_depth];
    logic [phys_bits-1:0]        e_ps1 [station_depth];
    logic [phys_bits-1:0]        e_ps2 [station_depth];
    logic [station_depth-1:0]    e_rdy1;
    logic [station_depth-1:0]    e_rdy2;
    logic [station_idx_bits-1:0] free_idx;
    logic [station_idx_bits-1:0] sel_idx;
    logic                        found;

    always_comb begin
        free_idx = '0;
        for (int i = station_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = station_idx_bits'(i);
            end
        end

        // oldest entry with both operands ready
        sel_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < station_depth; i++) begin
            if (valid[i] && e_rdy1[i] && e_rdy2[i] && (!found || (age[i] > age[sel_idx]))) begin
                sel_idx = station_idx_bits'(i);
                found   = 1'b1;
            end
        end
    end

    assign full   = &valid;
    assign req    = found;
    assign r_inst = e_inst[sel_idx];
    assign r_pc   = e_pc[sel_idx];
    assign r_pd   = e_pd[sel_idx];
    assign r_ps1  = e_ps1[sel_idx];
    assign r_ps2  = e_ps2[sel_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            for (int i = 0; i < station_depth; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < station_depth; i++) begin
                if (grant && (sel_idx == station_idx_bits'(i))) begin
                    valid[i] <= 1'b0;
                end else if (valid[i]) begin
                    if (write && !(grant && (age[i] > age[sel_idx]))) begin
                        age[i] <= age[i] + 1'b1;
                    end else if (!write && grant && (age[i] > age[sel_idx])) begin
                        age[i] <= age[i] - 1'b1;
                    end
                end
            end
            if (write) begin
                valid[free_idx] <= 1'b1;
                age[free_idx]   <= '0;
            end
        end
    end

    // payload and operand wake-up
    always_ff @(posedge clk) begin
        for (int i = 0; i < station_depth; i++) begin
            if (valid[i] && wb_valid && (wb_pd == e_ps1[i])) begin
                e_rdy1[i] <= 1'b1;
            end
            if (valid[i] && wb_valid && (wb_pd == e_ps2[i])) begin
                e_rdy2[i] <= 1'b1;
            end
        end
        if (write) begin
            e_inst[free_idx] <= w_inst;
            e_pc[free_idx]   <= w_pc;
            e_pd[free_idx]   <= w_pd;
            e_ps1[free_idx]  <= w_ps1;
            e_ps2[free_idx]  <= w_ps2;
            e_rdy1[free_idx] <= w_rdy1 || (wb_valid && (wb_pd == w_ps1));
            e_rdy2[free_idx] <= w_rdy2 || (wb_valid && (wb_pd == w_ps2));
        end
    end

endmodule

// File: logic/rename_dispatch.sv
module rename_dispatch (
    input  logic [31:0]                          inst,
    input  logic [31:0]                          pc,
    input  logic                                 inst_valid,
    output logic                                 inst_taken,
    input  logic                                 fl_empty,
    input  logic [rename_pkg::phys_bits-1:0]     fl_head,
    output logic                                 fl_pop,
    output logic [rename_pkg::arch_bits-1:0]     rs1,
    output logic [rename_pkg::arch_bits-1:0]     rs2,
    input  logic [rename_pkg::phys_bits-1:0]     ps1,
    input  logic [rename_pkg::phys_bits-1:0]     ps2,
    input  logic                                 rdy1,
    input  logic                                 rdy2,
    output logic                                 map_we,
    output logic [rename_pkg::arch_bits-1:0]     map_rd,
    output logic [rename_pkg::phys_bits-1:0]     map_pd,
    input  logic [rename_pkg::class_count-1:0]   st_full,
    output logic [rename_pkg::class_count-1:0]   st_write,
    output logic [31:0]                          st_inst,
    output logic [31:0]                          st_pc,
    output logic [rename_pkg::phys_bits-1:0]     st_pd,
    output logic [rename_pkg::phys_bits-1:0]     st_ps1,
    output logic [rename_pkg::phys_bits-1:0]     st_ps2,
    output logic                                 st_rdy1,
    output logic                                 st_rdy2
);
    import rename_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [arch_bits-1:0]  rd;
    logic                  muldiv;
    logic                  writes;
    logic [class_bits-1:0] cls;

    always_comb begin
        opcode = inst[6:0];
        funct3 = inst[14:12];
        rd     = inst[11:7];
        muldiv = (opcode == op_reg) && (inst[31:25] == funct7_muldiv);

        // class selection
        if (muldiv && (funct3 inside {funct3_mul, funct3_mulh, funct3_mulhsu, funct3_mulhu})) begin
            cls = class_mul;
        end else if (muldiv && (funct3 inside {funct3_div, funct3_divu, funct3_rem, funct3_remu})) begin
            cls = class_div;
        end else if (opcode inside {op_jal, op_jalr, op_br}) begin
            cls = class_br;
        end else if (opcode inside {op_load, op_store}) begin
            cls = class_mem;
        end else begin
            cls = class_alu;
        end

        // nop and the zero word fall out via rd == x0
        writes = (rd != '0) && (opcode != op_br) && (opcode != op_store);

        // unread sources go to x0 so they count as ready
        rs1 = (opcode inside {op_lui, op_auipc, op_jal}) ? '0 : inst[19:15];
        rs2 = (opcode inside {op_br, op_store, op_reg}) ? inst[24:20] : '0;

        inst_taken = inst_valid && !st_full[cls] && !(writes && fl_empty);
        fl_pop     = inst_taken && writes;

        map_we = fl_pop;
        map_rd = rd;
        map_pd = fl_head;

        st_write = '0;
        if (inst_taken) begin
            st_write[cls] = 1'b1;
        end
        st_inst = inst;
        st_pc   = pc;
        st_pd   = writes ? fl_head : '0;
        st_ps1  = ps1;
        st_ps2  = ps2;
        st_rdy1 = rdy1;
        st_rdy2 = rdy2;
    end

endmodule

// File: logic/rename_table.sv
module rename_table (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [rename_pkg::arch_bits-1:0] rs1,
    input  logic [rename_pkg::arch_bits-1:0] rs2,
    output logic [rename_pkg::phys_bits-1:0] ps1,
    output logic [rename_pkg::phys_bits-1:0] ps2,
    output logic                            rdy1,
    output logic                            rdy2,
    input  logic                            map_we,
    input  logic [rename_pkg::arch_bits-1:0] map_rd,
    input  logic [rename_pkg::phys_bits-1:0] map_pd,
    input  logic                            wb_valid,
    input  logic [rename_pkg::phys_bits-1:0] wb_pd
);
    import rename_pkg::*;

    logic [phys_bits-1:0]  map [2**arch_bits];
    logic [phys_count-1:0] ready;

    // lookups see a writeback landing this cycle
    always_comb begin
        ps1  = map[rs1];
        ps2  = map[rs2];
        rdy1 = ready[ps1] || (wb_valid && (wb_pd == ps1));
        rdy2 = ready[ps2] || (wb_valid && (wb_pd == ps2));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**arch_bits; i++) begin
                map[i] <= phys_bits'(i);
            end
            ready <= '1;
        end else begin
            if (wb_valid) begin
                ready[wb_pd] <= 1'b1;
            end
            // x0 stays pinned to physical 0
            if (map_we && (map_rd != '0)) begin
                map[map_rd]   <= map_pd;
                ready[map_pd] <= 1'b0;
            end
        end
    end

endmodule

// File: logic/free_list.sv
module free_list (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pop,
    input  logic                            push,
    input  logic [rename_pkg::phys_bits-1:0] push_pd,
    output logic [rename_pkg::phys_bits-1:0] head_pd,
    output logic                            empty
);
    import rename_pkg::*;

    logic [phys_bits-1:0] slots [phys_count];
    logic [phys_bits-1:0] head;
    logic [phys_bits-1:0] tail;
    logic [phys_bits:0]   count;

    assign head_pd = slots[head];
    assign empty   = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // registers above the architectural range start out free
            for (int i = 0; i < 2**arch_bits; i++) begin
                slots[i] <= phys_bits'(i + 2**arch_bits);
            end
            head  <= '0;
            tail  <= phys_bits'(2**arch_bits);
            count <= (phys_bits+1)'(2**arch_bits);
        end else begin
            if (push) begin
                slots[tail] <= push_pd;
                tail        <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // pointers wrap on their own at 64
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/rename_pkg.sv
package rename_pkg;

    // register file sizes
    localparam int arch_bits  = 5;
    localparam int phys_bits  = 6;
    localparam int phys_count = 64;

    // instruction classes, one station per class
    localparam int class_bits  = 3;
    localparam int class_count = 5;

    localparam logic [class_bits-1:0] class_alu = 3'd0;
    localparam logic [class_bits-1:0] class_mul = 3'd1;
    localparam logic [class_bits-1:0] class_div = 3'd2;
    localparam logic [class_bits-1:0] class_br  = 3'd3;
    localparam logic [class_bits-1:0] class_mem = 3'd4;

    // rv32 base opcodes
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // m extension
    localparam logic [2:0] funct3_mul    = 3'b000;
    localparam logic [2:0] funct3_mulh   = 3'b001;
    localparam logic [2:0] funct3_mulhsu = 3'b010;
    localparam logic [2:0] funct3_mulhu  = 3'b011;
    localparam logic [2:0] funct3_div    = 3'b100;
    localparam logic [2:0] funct3_divu   = 3'b101;
    localparam logic [2:0] funct3_rem    = 3'b110;
    localparam logic [2:0] funct3_remu   = 3'b111;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // reservation station geometry
    localparam int station_depth    = 4;
    localparam int station_idx_bits = $clog2(station_depth);

endpackage
